//--- verilog/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Datapath width for instructions, PC and immediates
`define DATA_W 16

// Register number width, eight registers
`define REG_W 3

// Culled instruction, opcode NOP with zero fields
`define NOP_WORD 16'h0800

// JAL writes its return address here
`define LINK_REG 7

`endif

//--- verilog/cpu_pkg.sv
`default_nettype none

`include "cpu_defines.svh"

package cpu_pkg;

    typedef logic [`DATA_W-1:0] word_t;       // Instruction, PC or immediate
    typedef logic [`REG_W-1:0]  regAddr_t;    // Register number
    typedef logic [1:0]         linkSel_t;    // Link source select
    typedef logic [5:0]         fwdCode_t;    // {rs hits, rt hits}, newest first

    // Opcode field, bits 15..11
    typedef enum logic [4:0] {
        ADD  = 5'd0,
        NOP  = 5'd1,
        ADDI = 5'd2,
        LD   = 5'd3,
        ST   = 5'd4,
        BEQ  = 5'd5,
        J    = 5'd6,
        JAL  = 5'd7,
        JR   = 5'd8,
        HALT = 5'd9
    } opcode_e;

    localparam linkSel_t LINK_NONE = 2'd0;    // No link write
    localparam linkSel_t LINK_PC2  = 2'd1;    // Link PC+2

    // Destinations remembered for forwarding
    localparam int HIST_DEPTH = 3;

endpackage

`default_nettype wire

//--- verilog/pipe_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface pipe_ctrl_if;
    import cpu_pkg::*;

    word_t    instr;           // Fetched word
    word_t    immExt;          // Sign-extended immediate
    word_t    pc;              // Address of this instruction

    // Decode controls
    linkSel_t linkReg;
    regAddr_t writeRegAddr;
    logic     regWrite;
    logic     bFlag;
    logic     jFlag;
    logic     regJmp;

    // Execute controls
    logic     aluSel;
    fwdCode_t forwards;

    // Memory controls
    logic     memEnable;
    logic     memWr;
    logic     halt;

    // Writeback control
    logic     val2Reg;

    modport producer (
        output instr, immExt, pc,
        output linkReg, writeRegAddr, regWrite, bFlag, jFlag, regJmp,
        output aluSel, forwards,
        output memEnable, memWr, halt,
        output val2Reg
    );

    modport consumer (
        input instr, immExt, pc,
        input linkReg, writeRegAddr, regWrite, bFlag, jFlag, regJmp,
        input aluSel, forwards,
        input memEnable, memWr, halt,
        input val2Reg
    );

endinterface

`default_nettype wire

//--- verilog/fetchUnit.sv
`timescale 1ns/1ps
`default_nettype none

module fetchUnit (
    input  wire                 clk,
    input  wire                 rstN,
    input  wire                 instrStall,
    input  wire                 memStall,
    input  wire                 branchTaken,
    input  wire cpu_pkg::word_t branchTarget,
    output cpu_pkg::word_t      imemAddr
);
    import cpu_pkg::*;

    // Byte addressed, two bytes per instruction
    localparam word_t PC_STEP = word_t'(2);

    word_t pcQ;
    word_t pcNext;
    word_t pcInc;
    logic  stall;

    assign stall = instrStall | memStall;
    assign pcInc = pcQ + PC_STEP;               // Sequential fetch

    // Next PC select; a redirect must not be lost behind a stall
    always_comb begin
        pcNext = pcQ;                           // Hold
        if (branchTaken) begin
            pcNext = branchTarget;              // Redirect beats stall
        end else if (!stall) begin
            pcNext = pcInc;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pcQ <= '0;                          // Boot from address 0
        end else begin
            pcQ <= pcNext;
        end
    end

    // Same value goes to imem and down the pipe as the instruction PC
    assign imemAddr = pcQ;

endmodule

`default_nettype wire

//--- verilog/instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module instrDecoder (
    input  wire                 clk,
    input  wire                 rstN,
    input  wire cpu_pkg::word_t imemData,
    input  wire cpu_pkg::word_t pc,
    input  wire                 instrStall,
    input  wire                 memStall,
    input  wire                 branchTaken,
    pipe_ctrl_if.producer       ctrl
);
    import cpu_pkg::*;

    opcode_e  opcode;
    regAddr_t rd;
    regAddr_t rs;
    regAddr_t rt;
    word_t    imm5;
    word_t    imm8;
    word_t    imm11;
    word_t    immExt;
    linkSel_t linkReg;
    regAddr_t writeRegAddr;
    logic     regWrite;
    logic     bFlag;
    logic     jFlag;
    logic     regJmp;
    logic     aluSel;
    logic     memEnable;
    logic     memWr;
    logic     halt;
    logic     val2Reg;
    fwdCode_t forwards;
    logic     shiftEn;
    logic     histValid [HIST_DEPTH];   // Entry wrote a register
    regAddr_t histAddr  [HIST_DEPTH];   // Index 0 is one instruction back

    assign opcode = opcode_e'(imemData[15:11]);
    assign rd     = imemData[10:8];
    assign rs     = imemData[7:5];
    assign rt     = imemData[4:2];

    // Immediate formats, all sign-extended
    assign imm5  = {{(`DATA_W-5){imemData[4]}}, imemData[4:0]};
    assign imm8  = {{(`DATA_W-8){imemData[7]}}, imemData[7:0]};
    assign imm11 = {{(`DATA_W-11){imemData[10]}}, imemData[10:0]};

    always_comb begin
        immExt       = '0;
        linkReg      = LINK_NONE;
        writeRegAddr = rd;
        regWrite     = 1'b0;
        bFlag        = 1'b0;
        jFlag        = 1'b0;
        regJmp       = 1'b0;
        aluSel       = 1'b0;
        memEnable    = 1'b0;
        memWr        = 1'b0;
        halt         = 1'b0;
        val2Reg      = 1'b0;
        case (opcode)
            ADD: begin
                regWrite = 1'b1;
            end
            ADDI: begin
                regWrite = 1'b1;
                aluSel   = 1'b1;
                immExt   = imm5;
            end
            LD: begin
                regWrite  = 1'b1;
                aluSel    = 1'b1;             // Base plus offset
                memEnable = 1'b1;
                val2Reg   = 1'b1;
                immExt    = imm5;
            end
            ST: begin
                aluSel    = 1'b1;
                memEnable = 1'b1;
                memWr     = 1'b1;
                immExt    = imm5;
            end
            BEQ: begin
                bFlag  = 1'b1;
                immExt = imm8;
            end
            J: begin
                jFlag  = 1'b1;
                immExt = imm11;
            end
            JAL: begin
                jFlag        = 1'b1;
                regWrite     = 1'b1;
                linkReg      = LINK_PC2;
                writeRegAddr = regAddr_t'(`LINK_REG);
                immExt       = imm11;
            end
            JR: begin
                regJmp = 1'b1;
            end
            HALT: begin
                halt = 1'b1;
            end
            default: begin
            end                               // NOP and unused codes
        endcase
    end

    // History moves with the IF/ID register
    assign shiftEn = ~(instrStall | memStall);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < HIST_DEPTH; i++) begin
                histValid[i] <= 1'b0;
            end
        end else if (shiftEn) begin
            for (int i = HIST_DEPTH - 1; i > 0; i--) begin
                histValid[i] <= histValid[i-1];
            end
            histValid[0] <= regWrite & ~branchTaken;   // Culled slot is empty
        end
    end

    always_ff @(posedge clk) begin
        if (shiftEn) begin
            for (int i = HIST_DEPTH - 1; i > 0; i--) begin
                histAddr[i] <= histAddr[i-1];
            end
            histAddr[0] <= writeRegAddr;      // R7 for JAL
        end
    end

    // rs hits in the upper half, rt hits in the lower half
    always_comb begin
        for (int i = 0; i < HIST_DEPTH; i++) begin
            forwards[2*HIST_DEPTH-1-i] = histValid[i] & (rs == histAddr[i]);
            forwards[HIST_DEPTH-1-i]   = histValid[i] & (rt == histAddr[i]);
        end
    end

    assign ctrl.instr        = imemData;
    assign ctrl.immExt       = immExt;
    assign ctrl.pc           = pc;
    assign ctrl.linkReg      = linkReg;
    assign ctrl.writeRegAddr = writeRegAddr;
    assign ctrl.regWrite     = regWrite;
    assign ctrl.bFlag        = bFlag;
    assign ctrl.jFlag        = jFlag;
    assign ctrl.regJmp       = regJmp;
    assign ctrl.aluSel       = aluSel;
    assign ctrl.forwards     = forwards;
    assign ctrl.memEnable    = memEnable;
    assign ctrl.memWr        = memWr;
    assign ctrl.halt         = halt;
    assign ctrl.val2Reg      = val2Reg;

endmodule

`default_nettype wire

//--- verilog/ifIdReg.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module ifIdReg (
    input  wire                  clk,
    input  wire                  rstN,
    pipe_ctrl_if.consumer        ctrl,
    input  wire                  instrStall,
    input  wire                  memStall,
    input  wire                  branchTaken,
    output cpu_pkg::word_t       instrOut,
    output cpu_pkg::word_t       immExtOut,
    output cpu_pkg::word_t       pcOut,
    output cpu_pkg::linkSel_t    linkRegOut,
    output cpu_pkg::regAddr_t    writeRegAddrOut,
    output logic                 regWriteOut,
    output logic                 bFlagOut,
    output logic                 jFlagOut,
    output logic                 regJmpOut,
    output logic                 aluSelOut,
    output cpu_pkg::fwdCode_t    forwardsOut,
    output logic                 memEnableOut,
    output logic                 memWrOut,
    output logic                 haltOut,
    output logic                 val2RegOut
);
    import cpu_pkg::*;

    // Control group widths
    localparam int ID_W  = $bits(linkSel_t) + $bits(regAddr_t) + 4;
    localparam int EX_W  = 1 + $bits(fwdCode_t);
    localparam int MEM_W = 3;

    logic             captureEn;
    word_t            instrQ;
    word_t            immExtQ;
    word_t            pcQ;
    logic [ID_W-1:0]  idCtrlQ;
    logic [EX_W-1:0]  exCtrlQ;
    logic [MEM_W-1:0] memCtrlQ;
    logic             wbCtrlQ;

    assign captureEn = ~(instrStall | memStall);   // Freeze with fetch

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            instrQ   <= '0;
            immExtQ  <= '0;
            pcQ      <= '0;
            idCtrlQ  <= '0;
            exCtrlQ  <= '0;
            memCtrlQ <= '0;
            wbCtrlQ  <= 1'b0;
        end else if (captureEn) begin
            instrQ   <= ctrl.instr;
            immExtQ  <= ctrl.immExt;
            pcQ      <= ctrl.pc;
            idCtrlQ  <= {ctrl.linkReg, ctrl.writeRegAddr, ctrl.regWrite,
                         ctrl.bFlag, ctrl.jFlag, ctrl.regJmp};
            exCtrlQ  <= {ctrl.aluSel, ctrl.forwards};
            memCtrlQ <= {ctrl.memEnable, ctrl.memWr, ctrl.halt};
            wbCtrlQ  <= ctrl.val2Reg;
        end
    end

    // Taken branch turns this slot into a bubble in the same cycle
    assign instrOut  = branchTaken ? word_t'(`NOP_WORD) : instrQ;
    assign immExtOut = immExtQ;                    // Not culled
    assign pcOut     = pcQ;

    assign {linkRegOut, writeRegAddrOut, regWriteOut, bFlagOut, jFlagOut, regJmpOut} =
        branchTaken ? {ID_W{1'b0}} : idCtrlQ;
    assign {aluSelOut, forwardsOut} = branchTaken ? {EX_W{1'b0}} : exCtrlQ;
    assign {memEnableOut, memWrOut, haltOut} = branchTaken ? {MEM_W{1'b0}} : memCtrlQ;
    assign val2RegOut = branchTaken ? 1'b0 : wbCtrlQ;

endmodule

`default_nettype wire

//--- verilog/frontEnd.sv
`timescale 1ns/1ps
`default_nettype none

module frontEnd (
    input  wire                  clk,
    input  wire                  rstN,
    input  wire                  instrStall,
    input  wire                  memStall,
    input  wire                  branchTaken,
    input  wire cpu_pkg::word_t  branchTarget,
    input  wire cpu_pkg::word_t  imemData,
    output cpu_pkg::word_t       imemAddr,
    output cpu_pkg::word_t       instrOut,
    output cpu_pkg::word_t       immExtOut,
    output cpu_pkg::word_t       pcOut,
    output cpu_pkg::linkSel_t    linkRegOut,
    output cpu_pkg::regAddr_t    writeRegAddrOut,
    output logic                 regWriteOut,
    output logic                 bFlagOut,
    output logic                 jFlagOut,
    output logic                 regJmpOut,
    output logic                 aluSelOut,
    output cpu_pkg::fwdCode_t    forwardsOut,
    output logic                 memEnableOut,
    output logic                 memWrOut,
    output logic                 haltOut,
    output logic                 val2RegOut
);
    import cpu_pkg::*;

    word_t fetchPc;            // Address of the word on imemData

    pipe_ctrl_if ctrlBus ();   // Decoder to IF/ID

    fetchUnit uFetch (
        .clk          (clk),
        .rstN         (rstN),
        .instrStall   (instrStall),
        .memStall     (memStall),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .imemAddr     (fetchPc)
    );

    assign imemAddr = fetchPc;

    instrDecoder uDecode (
        .clk         (clk),
        .rstN        (rstN),
        .imemData    (imemData),
        .pc          (fetchPc),
        .instrStall  (instrStall),
        .memStall    (memStall),
        .branchTaken (branchTaken),
        .ctrl        (ctrlBus.producer)
    );

    ifIdReg uIfId (
        .clk             (clk),
        .rstN            (rstN),
        .ctrl            (ctrlBus.consumer),
        .instrStall      (instrStall),
        .memStall        (memStall),
        .branchTaken     (branchTaken),
        .instrOut        (instrOut),
        .immExtOut       (immExtOut),
        .pcOut           (pcOut),
        .linkRegOut      (linkRegOut),
        .writeRegAddrOut (writeRegAddrOut),
        .regWriteOut     (regWriteOut),
        .bFlagOut        (bFlagOut),
        .jFlagOut        (jFlagOut),
        .regJmpOut       (regJmpOut),
        .aluSelOut       (aluSelOut),
        .forwardsOut     (forwardsOut),
        .memEnableOut    (memEnableOut),
        .memWrOut        (memWrOut),
        .haltOut         (haltOut),
        .val2RegOut      (val2RegOut)
    );

endmodule

`default_nettype wire

//--- dv/tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
    parameter real HALF_PERIOD = 5.0      // 10 ns clock
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always begin
        #(HALF_PERIOD) clk = ~clk;
    end

endmodule

`default_nettype wire

//--- dv/frontEnd_assertions.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module frontEnd_assertions (
    input wire                    clk,
    input wire                    rstN,
    input wire                    instrStall,
    input wire                    memStall,
    input wire                    branchTaken,
    input wire cpu_pkg::word_t    branchTarget,
    input wire cpu_pkg::word_t    imemAddr,
    input wire cpu_pkg::word_t    instrOut,
    input wire cpu_pkg::word_t    immExtOut,
    input wire cpu_pkg::word_t    pcOut,
    input wire cpu_pkg::linkSel_t linkRegOut,
    input wire cpu_pkg::regAddr_t writeRegAddrOut,
    input wire                    regWriteOut,
    input wire                    bFlagOut,
    input wire                    jFlagOut,
    input wire                    regJmpOut,
    input wire                    aluSelOut,
    input wire cpu_pkg::fwdCode_t forwardsOut,
    input wire                    memEnableOut,
    input wire                    memWrOut,
    input wire                    haltOut,
    input wire                    val2RegOut,
    input wire cpu_pkg::word_t    expAddr,
    input wire cpu_pkg::word_t    expInstr,
    input wire cpu_pkg::word_t    expImm,
    input wire cpu_pkg::word_t    expPc,
    input wire [13:0]             expCtrl,
    input wire cpu_pkg::fwdCode_t expFwd
);
    import cpu_pkg::*;

    int          failCount = 0;           // Read by the testbench
    logic        stall;
    logic [13:0] ctrlOut;

    assign stall   = instrStall | memStall;
    assign ctrlOut = {linkRegOut, writeRegAddrOut, regWriteOut, bFlagOut, jFlagOut,
                      regJmpOut, aluSelOut, memEnableOut, memWrOut, haltOut, val2RegOut};

    aResetQuiet: assert property (@(posedge clk)
        $rose(rstN) |-> (imemAddr == '0 && ctrlOut == '0 && forwardsOut == '0))
        else begin
            failCount++;
            $error("imemAddr or a control output was not zero right after reset");
        end

    aAddr: assert property (@(posedge clk) disable iff (!rstN) imemAddr == expAddr)
        else begin
            failCount++;
            $error("mismatch t=%0t imemAddr exp=%h got=%h",
                   $time, $sampled(expAddr), $sampled(imemAddr));
        end

    aInstr: assert property (@(posedge clk) disable iff (!rstN)
        !branchTaken |-> instrOut == expInstr)
        else begin
            failCount++;
            $error("mismatch t=%0t instrOut exp=%h got=%h",
                   $time, $sampled(expInstr), $sampled(instrOut));
        end

    // Immediate and PC pass through a cull unchanged
    aImm: assert property (@(posedge clk) disable iff (!rstN) immExtOut == expImm)
        else begin
            failCount++;
            $error("mismatch t=%0t immExtOut exp=%h got=%h",
                   $time, $sampled(expImm), $sampled(immExtOut));
        end

    aPc: assert property (@(posedge clk) disable iff (!rstN) pcOut == expPc)
        else begin
            failCount++;
            $error("mismatch t=%0t pcOut exp=%h got=%h", $time, $sampled(expPc), $sampled(pcOut));
        end

    aCtrl: assert property (@(posedge clk) disable iff (!rstN)
        !branchTaken |-> ctrlOut == expCtrl)
        else begin
            failCount++;
            $error("mismatch t=%0t controls exp=%h got=%h",
                   $time, $sampled(expCtrl), $sampled(ctrlOut));
        end

    aFwd: assert property (@(posedge clk) disable iff (!rstN)
        !branchTaken |-> forwardsOut == expFwd)
        else begin
            failCount++;
            $error("mismatch t=%0t forwardsOut exp=%b got=%b",
                   $time, $sampled(expFwd), $sampled(forwardsOut));
        end

    aCull: assert property (@(posedge clk) disable iff (!rstN)
        branchTaken |-> (instrOut == `NOP_WORD && ctrlOut == '0 && forwardsOut == '0))
        else begin
            failCount++;
            $error("taken branch at t=%0t did not cull the IF/ID outputs to a NOP", $time);
        end

    aRedirect: assert property (@(posedge clk) disable iff (!rstN)
        branchTaken |=> imemAddr == $past(branchTarget))
        else begin
            failCount++;
            $error("mismatch t=%0t imemAddr exp=%h got=%h",
                   $time, $past(branchTarget, 1), $sampled(imemAddr));
        end

    // A branch in the next cycle changes instrOut, so only quiet cycles are compared
    aHold: assert property (@(posedge clk) disable iff (!rstN)
        (stall && !branchTaken) |=> (!branchTaken |-> ($stable(imemAddr) && $stable(pcOut)
            && $stable(instrOut) && $stable(ctrlOut) && $stable(forwardsOut))))
        else begin
            failCount++;
            $error("stall at t=%0t did not hold imemAddr and the IF/ID outputs", $time);
        end

endmodule

`default_nettype wire

//--- dv/frontEnd_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module frontEnd_tb;
    import cpu_pkg::*;

    localparam int RESET_CYCLES  = 16;
    localparam int DECODE_CYCLES = 30;
    localparam int STALL_CYCLES  = 80;
    localparam int BRANCH_CYCLES = 80;
    localparam int FWD_CYCLES    = 24;
    localparam int CYCLE_LIMIT   = RESET_CYCLES + DECODE_CYCLES + STALL_CYCLES
                                   + BRANCH_CYCLES + FWD_CYCLES + 60;   // Margin for reports

    wire         clk;
    logic        rstN;
    logic        instrStall;
    logic        memStall;
    logic        branchTaken;
    word_t       branchTarget;
    word_t       imemData;
    word_t       imemAddr;
    word_t       instrOut;
    word_t       immExtOut;
    word_t       pcOut;
    linkSel_t    linkRegOut;
    regAddr_t    writeRegAddrOut;
    logic        regWriteOut;
    logic        bFlagOut;
    logic        jFlagOut;
    logic        regJmpOut;
    logic        aluSelOut;
    fwdCode_t    forwardsOut;
    logic        memEnableOut;
    logic        memWrOut;
    logic        haltOut;
    logic        val2RegOut;
    word_t       imem [256];             // Instruction memory model
    word_t       expAddr;
    word_t       expInstr;
    word_t       expImm;
    word_t       expPc;
    logic [13:0] expCtrl;                // {link, dest, regWrite, b, j, jr, alu, memEn, memWr, halt, v2r}
    fwdCode_t    expFwd;
    logic [2:0]  histWr;                 // Bit 0 is one instruction back
    regAddr_t    histDest [3];
    word_t       fetchWord;
    logic [13:0] ctrlNow;
    fwdCode_t    fwdNow;
    int          seed = 84099;
    int          cycleCount = 0;
    int          testsRun = 0;
    int          testsFailed = 0;

    tb_clkgen uClk (.clk(clk));

    frontEnd u_dut (.*);

    bind frontEnd frontEnd_assertions uChecks (
        .*,
        .expAddr  (frontEnd_tb.expAddr),
        .expInstr (frontEnd_tb.expInstr),
        .expImm   (frontEnd_tb.expImm),
        .expPc    (frontEnd_tb.expPc),
        .expCtrl  (frontEnd_tb.expCtrl),
        .expFwd   (frontEnd_tb.expFwd)
    );

    assign imemData = imem[imemAddr[8:1]];    // Halfword index into 256 words

    function automatic logic [13:0] ctrlFields(input word_t w);
        opcode_e op;
        logic    isJal;
        op    = opcode_e'(w[15:11]);
        isJal = (op == JAL);
        return {isJal ? 2'd1 : 2'd0, isJal ? regAddr_t'(`LINK_REG) : w[10:8],
                op inside {ADD, ADDI, LD, JAL}, op == BEQ, op inside {J, JAL}, op == JR,
                op inside {ADDI, LD, ST}, op inside {LD, ST}, op == ST, op == HALT, op == LD};
    endfunction

    function automatic word_t immField(input word_t w);
        case (opcode_e'(w[15:11]))
            ADDI, LD, ST: return {{11{w[4]}}, w[4:0]};
            BEQ:          return {{8{w[7]}}, w[7:0]};
            J, JAL:       return {{5{w[10]}}, w[10:0]};
            default:      return '0;
        endcase
    endfunction

    function automatic word_t encode(input opcode_e op, input int rd, input int rs, input int rt);
        return {op, 3'(rd), 3'(rs), 3'(rt), 2'b00};
    endfunction

    // Reference model of fetch, decode and the IF/ID register
    assign fetchWord = imem[expAddr[8:1]];
    assign ctrlNow   = ctrlFields(fetchWord);

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            fwdNow[5-i] = histWr[i] && (fetchWord[7:5] == histDest[i]);
            fwdNow[2-i] = histWr[i] && (fetchWord[4:2] == histDest[i]);
        end
    end

    always @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            expAddr  <= '0;
            expInstr <= '0;
            expImm   <= '0;
            expPc    <= '0;
            expCtrl  <= '0;
            expFwd   <= '0;
            histWr   <= '0;
        end else begin
            if (branchTaken) begin
                expAddr <= branchTarget;
            end else if (!(instrStall || memStall)) begin
                expAddr <= expAddr + 16'd2;
            end
            if (!(instrStall || memStall)) begin
                expInstr    <= fetchWord;
                expImm      <= immField(fetchWord);
                expPc       <= expAddr;
                expCtrl     <= ctrlNow;
                expFwd      <= fwdNow;
                histWr      <= {histWr[1:0], ctrlNow[8] & ~branchTaken};   // Culled slot
                histDest[2] <= histDest[1];
                histDest[1] <= histDest[0];
                histDest[0] <= ctrlNow[11:9];
            end
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the tests did not complete", cycleCount);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic loadProgram();
        for (int i = 0; i < 256; i++) begin
            imem[i] = {5'($unsigned($random(seed)) % 10), 11'($random(seed))};
        end
        for (int i = 0; i < 10; i++) begin
            imem[i][15:11] = 5'(i);               // Every opcode early in the run
        end
        imem[128] = encode(ADD, 1, 0, 0);
        imem[129] = encode(ADD, 2, 1, 1);
        imem[130] = encode(ST, 3, 2, 1);          // Writes nothing
        imem[131] = encode(ADD, 4, 3, 2);
        imem[132] = encode(JAL, 0, 0, 0);
        imem[133] = encode(ADD, 5, 7, 4);
        imem[134] = encode(ADD, 6, 5, 5);         // Enters on the cull edge
        imem[135] = encode(ADD, 6, 5, 0);
        imem[136] = encode(ADD, 1, 6, 5);
        imem[137] = encode(ADD, 2, 1, 6);
    endtask

    task automatic finishTest(input string name, input int startFails);
        int newFails;
        @(negedge clk);
        newFails = u_dut.uChecks.failCount - startFails;
        testsRun++;
        if (newFails != 0) begin
            testsFailed++;
        end
        $display("test %-8s %s, %0d assertion failures", name,
                 (newFails == 0) ? "passed" : "failed", newFails);
    endtask

    task automatic toggleStalls();
        int startFails;
        startFails = u_dut.uChecks.failCount;
        repeat (STALL_CYCLES) begin
            @(posedge clk);
            instrStall <= (($unsigned($random(seed)) % 4) == 0);
            memStall   <= (($unsigned($random(seed)) % 5) == 0);
        end
        @(posedge clk);
        instrStall <= 1'b0;
        memStall   <= 1'b0;
        finishTest("stall", startFails);
    endtask

    task automatic injectBranches();
        int   startFails;
        logic lastBranch;
        logic takeNow;
        startFails = u_dut.uChecks.failCount;
        lastBranch = 1'b0;
        repeat (BRANCH_CYCLES) begin
            @(posedge clk);
            takeNow = !lastBranch && (($unsigned($random(seed)) % 6) == 0);
            branchTaken  <= takeNow;               // Never two in a row
            branchTarget <= word_t'($random(seed)) & 16'h01FE;
            instrStall   <= (($unsigned($random(seed)) % 7) == 0);
            lastBranch = takeNow;
        end
        @(posedge clk);
        branchTaken <= 1'b0;
        instrStall  <= 1'b0;
        finishTest("branch", startFails);
    endtask

    task automatic walkDependencies();
        int startFails;
        startFails = u_dut.uChecks.failCount;
        @(posedge clk);
        branchTaken  <= 1'b1;
        branchTarget <= 16'h0100;
        @(posedge clk);
        branchTaken <= 1'b0;
        repeat (6) @(posedge clk);
        branchTaken  <= 1'b1;                      // Cull mid sequence
        branchTarget <= 16'h0110;
        @(posedge clk);
        branchTaken <= 1'b0;
        repeat (FWD_CYCLES) @(posedge clk);
        finishTest("forward", startFails);
    endtask

    initial begin
        int startFails;
        rstN         = 1'b0;
        instrStall   = 1'b0;
        memStall     = 1'b0;
        branchTaken  = 1'b0;
        branchTarget = '0;
        loadProgram();
        startFails = u_dut.uChecks.failCount;
        repeat (RESET_CYCLES) @(posedge clk);
        rstN <= 1'b1;
        repeat (2) @(posedge clk);
        finishTest("reset", startFails);
        startFails = u_dut.uChecks.failCount;
        repeat (DECODE_CYCLES) @(posedge clk);
        finishTest("decode", startFails);
        toggleStalls();
        injectBranches();
        walkDependencies();
        $display("summary: %0d tests run, %0d failed, %0d assertion failures",
                 testsRun, testsFailed, u_dut.uChecks.failCount);
        if (testsFailed == 0 && u_dut.uChecks.failCount == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+verilog
verilog/cpu_pkg.sv
verilog/pipe_ctrl_if.sv
verilog/fetchUnit.sv
verilog/instrDecoder.sv
verilog/ifIdReg.sv
verilog/frontEnd.sv
dv/tb_clkgen.sv
dv/frontEnd_assertions.sv
dv/frontEnd_tb.sv
